//--- include/xadc_drp_defines.svh
`ifndef XADC_DRP_DEFINES_SVH
`define XADC_DRP_DEFINES_SVH

// --------------------------------------------------
// DRP bus geometry
// --------------------------------------------------

// Conversion word as read back over the DRP
`define XADC_DRP_DATA_WIDTH 16

// DRP register address
`define XADC_DRP_ADDR_WIDTH 7

// --------------------------------------------------
// Sample buffering
// --------------------------------------------------

`define XADC_DRP_FIFO_DEPTH 8  // Words per channel, power of two

`endif

//--- run_sim.sh
#!/bin/sh
# Build and run the XADC DRP testbench with Verilator

ROOT=$(cd "$(dirname "$0")" && pwd)
cd "$ROOT" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_xadc_drp_axis

verilator --binary --timing --assert -f xadc_drp_axis.f \
    --top-module "$TOP" -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

//--- source/axis_sample_fifo.sv
`default_nettype none

`include "xadc_drp_defines.svh"

module axis_sample_fifo #(
    parameter int DEPTH = `XADC_DRP_FIFO_DEPTH
) (
    input  logic                            xadc_dclk,
    input  logic                            rst_n,

    // Write port from the reader
    input  logic                            push,
    input  logic [`XADC_DRP_DATA_WIDTH-1:0] push_data,
    output logic                            full,

    // Stream out
    output logic [`XADC_DRP_DATA_WIDTH-1:0] tdata,
    output logic                            tvalid,
    input  logic                            tready
);
    localparam int AW = $clog2(DEPTH);

    logic [`XADC_DRP_DATA_WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]                   wr_ptr;
    logic [AW-1:0]                   rd_ptr;
    logic [AW:0]                     count;
    logic                            wr_en;
    logic                            rd_en;

    assign full   = (count == (AW+1)'(DEPTH));
    assign tvalid = (count != '0);
    assign tdata  = mem[rd_ptr];  // Show-ahead head word

    assign wr_en = push;
    assign rd_en = tvalid && tready;

    // --------------------------------------------------
    // Pointers and fill level
    // --------------------------------------------------

    // Pointers wrap naturally for a power-of-two depth
    always_ff @(posedge xadc_dclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or push with pop
            endcase
        end
    end

    // Storage
    always_ff @(posedge xadc_dclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    a_count_bound : assert property (
        @(posedge xadc_dclk) disable iff (!rst_n)
        count <= (AW+1)'(DEPTH)
    );

endmodule

`default_nettype wire

//--- source/xadc_channel_sequencer.sv
`default_nettype none

module xadc_channel_sequencer (
    input  logic xadc_dclk,
    input  logic rst_n,
    input  logic xadc_eos,
    xadc_req_io.seq req
);
    import xadc_drp_pkg::*;

    typedef enum logic [1:0] {
        seq_idle,
        seq_voltage,
        seq_current
    } seq_state_t;

    seq_state_t state;

    // --------------------------------------------------
    // Sweep control
    // --------------------------------------------------

    // One EOS gives a voltage read then a current read
    always_ff @(posedge xadc_dclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= seq_idle;
            req.req  <= 1'b0;
            req.addr <= XADC_DRP_ADDR_VOLTAGE_CHANNEL;
            req.chan <= CHAN_VOLTAGE;
        end else begin
            req.req <= 1'b0;  // Pulse only
            case (state)
                seq_idle: begin
                    if (xadc_eos) begin
                        req.req  <= 1'b1;
                        req.addr <= XADC_DRP_ADDR_VOLTAGE_CHANNEL;
                        req.chan <= CHAN_VOLTAGE;
                        state    <= seq_voltage;
                    end
                end
                seq_voltage: begin
                    if (req.done) begin
                        req.req  <= 1'b1;
                        req.addr <= XADC_DRP_ADDR_CURRENT_CHANNEL;
                        req.chan <= CHAN_CURRENT;
                        state    <= seq_current;
                    end
                end
                seq_current: begin
                    if (req.done) begin
                        state <= seq_idle;  // EOS seen mid-sweep is dropped
                    end
                end
                default: begin
                    state <= seq_idle;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    // Reader must have finished the previous read
    a_req_not_busy : assert property (
        @(posedge xadc_dclk) disable iff (!rst_n)
        req.req |-> !req.busy
    );

endmodule

`default_nettype wire

//--- source/xadc_drp_axis_top.sv
`default_nettype none

`include "xadc_drp_defines.svh"

module xadc_drp_axis_top (
    input  logic                            xadc_dclk,
    input  logic                            rst_n,

    // XADC conversion and DRP
    input  logic                            xadc_eos,
    input  logic                            xadc_drdy,
    input  logic [`XADC_DRP_DATA_WIDTH-1:0] xadc_do,
    output logic [`XADC_DRP_ADDR_WIDTH-1:0] xadc_daddr,
    output logic                            xadc_den,

    // Voltage stream
    output logic [`XADC_DRP_DATA_WIDTH-1:0] voltage_tdata,
    output logic                            voltage_tvalid,
    input  logic                            voltage_tready,

    // Current stream
    output logic [`XADC_DRP_DATA_WIDTH-1:0] current_tdata,
    output logic                            current_tvalid,
    input  logic                            current_tready
);

    logic                            voltage_push;
    logic                            voltage_full;
    logic                            current_push;
    logic                            current_full;
    logic [`XADC_DRP_DATA_WIDTH-1:0] sample_data;  // Shared by both FIFOs

    xadc_req_io u_req_io ();

    // --------------------------------------------------
    // Decode and execute
    // --------------------------------------------------

    xadc_channel_sequencer u_channel_sequencer (
        .xadc_dclk (xadc_dclk),
        .rst_n     (rst_n),
        .xadc_eos  (xadc_eos),
        .req       (u_req_io.seq)
    );

    xadc_drp_reader u_drp_reader (
        .xadc_dclk    (xadc_dclk),
        .rst_n        (rst_n),
        .req          (u_req_io.rdr),
        .xadc_daddr   (xadc_daddr),
        .xadc_den     (xadc_den),
        .xadc_drdy    (xadc_drdy),
        .xadc_do      (xadc_do),
        .voltage_push (voltage_push),
        .voltage_full (voltage_full),
        .current_push (current_push),
        .current_full (current_full),
        .sample_data  (sample_data)
    );

    // --------------------------------------------------
    // Per-channel result FIFOs
    // --------------------------------------------------

    axis_sample_fifo #(
        .DEPTH (`XADC_DRP_FIFO_DEPTH)
    ) u_voltage_fifo (
        .xadc_dclk (xadc_dclk),
        .rst_n     (rst_n),
        .push      (voltage_push),
        .push_data (sample_data),
        .full      (voltage_full),
        .tdata     (voltage_tdata),
        .tvalid    (voltage_tvalid),
        .tready    (voltage_tready)
    );

    axis_sample_fifo #(
        .DEPTH (`XADC_DRP_FIFO_DEPTH)
    ) u_current_fifo (
        .xadc_dclk (xadc_dclk),
        .rst_n     (rst_n),
        .push      (current_push),
        .push_data (sample_data),
        .full      (current_full),
        .tdata     (current_tdata),
        .tvalid    (current_tvalid),
        .tready    (current_tready)
    );

endmodule

`default_nettype wire

//--- source/xadc_drp_pkg.sv
`default_nettype none

`include "xadc_drp_defines.svh"

package xadc_drp_pkg;

    // --------------------------------------------------
    // DRP status register addresses
    // --------------------------------------------------

    // Only the two monitored channels are read
    typedef enum logic [`XADC_DRP_ADDR_WIDTH-1:0] {
        XADC_DRP_ADDR_VOLTAGE_CHANNEL = 7'h01,  // VCCINT
        XADC_DRP_ADDR_CURRENT_CHANNEL = 7'h10   // VAUX0
    } xadc_drp_addr_t;

    // --------------------------------------------------
    // Destination channel
    // --------------------------------------------------

    // Picks which sample FIFO gets the word
    typedef enum logic {
        CHAN_VOLTAGE = 1'b0,
        CHAN_CURRENT = 1'b1
    } xadc_channel_t;

endpackage

`default_nettype wire

//--- source/xadc_drp_reader.sv
`default_nettype none

`include "xadc_drp_defines.svh"

module xadc_drp_reader (
    input  logic xadc_dclk,
    input  logic rst_n,
    xadc_req_io.rdr req,

    // DRP side
    output xadc_drp_pkg::xadc_drp_addr_t  xadc_daddr,
    output logic                          xadc_den,
    input  logic                          xadc_drdy,
    input  logic [`XADC_DRP_DATA_WIDTH-1:0] xadc_do,

    // FIFO side
    output logic                          voltage_push,
    input  logic                          voltage_full,
    output logic                          current_push,
    input  logic                          current_full,
    output logic [`XADC_DRP_DATA_WIDTH-1:0] sample_data
);
    import xadc_drp_pkg::*;

    typedef enum logic [1:0] {
        rd_idle,
        rd_wait,  // den sent and waiting on drdy
        rd_push   // Word held until FIFO has room
    } rd_state_t;

    rd_state_t                       state;
    xadc_channel_t                   chan_q;
    logic [`XADC_DRP_DATA_WIDTH-1:0] word_q;
    logic                            target_full;
    logic                            push_ok;

    // --------------------------------------------------
    // DRP transaction
    // --------------------------------------------------

    always_ff @(posedge xadc_dclk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= rd_idle;
            xadc_den   <= 1'b0;
            xadc_daddr <= XADC_DRP_ADDR_VOLTAGE_CHANNEL;
            chan_q     <= CHAN_VOLTAGE;
        end else begin
            xadc_den <= 1'b0;
            case (state)
                rd_idle: begin
                    if (req.req) begin
                        xadc_den   <= 1'b1;
                        xadc_daddr <= req.addr;
                        chan_q     <= req.chan;
                        state      <= rd_wait;
                    end
                end
                rd_wait: begin
                    if (xadc_drdy) begin
                        state <= rd_push;
                    end
                end
                rd_push: begin
                    if (push_ok) begin
                        state <= rd_idle;
                    end
                end
                default: begin
                    state <= rd_idle;
                end
            endcase
        end
    end

    // Conversion word captured on drdy
    always_ff @(posedge xadc_dclk) begin
        if (state == rd_wait && xadc_drdy) begin
            word_q <= xadc_do;
        end
    end

    // --------------------------------------------------
    // Routing to the channel FIFOs
    // --------------------------------------------------

    assign target_full  = (chan_q == CHAN_VOLTAGE) ? voltage_full : current_full;
    assign push_ok      = (state == rd_push) && !target_full;  // Back-pressure stall

    assign voltage_push = push_ok && (chan_q == CHAN_VOLTAGE);
    assign current_push = push_ok && (chan_q == CHAN_CURRENT);
    assign sample_data  = word_q;

    assign req.done = push_ok;
    assign req.busy = (state != rd_idle);

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    // XADC answers only an outstanding den
    a_drdy_outstanding : assert property (
        @(posedge xadc_dclk) disable iff (!rst_n)
        xadc_drdy |-> (state == rd_wait)
    );

endmodule

`default_nettype wire

//--- source/xadc_req_io.sv
`default_nettype none

interface xadc_req_io;
    import xadc_drp_pkg::*;

    logic           req;   // Start one read, single cycle
    xadc_drp_addr_t addr;  // Valid with req
    xadc_channel_t  chan;  // Valid with req
    logic           done;  // Word has gone into its FIFO
    logic           busy;  // Read in flight

    // Sequencer side
    modport seq (
        output req,
        output addr,
        output chan,
        input  done,
        input  busy
    );

    // Reader side
    modport rdr (
        input  req,
        input  addr,
        input  chan,
        output done,
        output busy
    );

endinterface

`default_nettype wire

//--- verif/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 8
) (
    output logic xadc_dclk,
    output logic rst_n
);

    initial begin
        xadc_dclk = 1'b0;
        forever #HALF_PERIOD xadc_dclk = ~xadc_dclk;
    end

    // Reset held low for the first cycles
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge xadc_dclk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/tb_xadc_drp_axis.sv
`default_nettype none

`include "xadc_drp_defines.svh"

module tb_xadc_drp_axis;

    localparam int         SWEEPS     = 40;
    localparam int         MAX_CYCLES = SWEEPS * 40 + 200;
    localparam int         DEPTH      = `XADC_DRP_FIFO_DEPTH;
    localparam logic [6:0] VOLT_ADDR  = 7'h01;  // VCCINT
    localparam logic [6:0] CURR_ADDR  = 7'h10;  // VAUX0

    logic        xadc_dclk;
    logic        rst_n;
    logic        xadc_eos;
    logic        xadc_drdy = 1'b0;
    logic [15:0] xadc_do   = '0;
    logic [6:0]  xadc_daddr;
    logic        xadc_den;
    logic [15:0] voltage_tdata;
    logic        voltage_tvalid;
    logic        voltage_tready;
    logic [15:0] current_tdata;
    logic        current_tvalid;
    logic        current_tready;

    logic [15:0] exp_voltage[$];
    logic [15:0] exp_current[$];
    logic [31:0] rng            = 32'hfc99;
    logic [6:0]  pending_addr   = '0;
    logic        model_busy     = 1'b0;
    logic        expect_current = 1'b0;
    logic        eos_seen       = 1'b0;
    int          wait_cnt;
    int          model_cycle;
    int          v_drdy_cycle;
    int          den_count;
    int          idle_eos;
    int          v_returned;
    int          c_returned;
    int          v_popped;
    int          cycle_cnt;

    tb_clock_gen u_clock_gen (
        .xadc_dclk (xadc_dclk),
        .rst_n     (rst_n)
    );

    xadc_drp_axis_top u_xadc_drp_axis_top (
        .xadc_dclk      (xadc_dclk),
        .rst_n          (rst_n),
        .xadc_eos       (xadc_eos),
        .xadc_drdy      (xadc_drdy),
        .xadc_do        (xadc_do),
        .xadc_daddr     (xadc_daddr),
        .xadc_den       (xadc_den),
        .voltage_tdata  (voltage_tdata),
        .voltage_tvalid (voltage_tvalid),
        .voltage_tready (voltage_tready),
        .current_tdata  (current_tdata),
        .current_tvalid (current_tvalid),
        .current_tready (current_tready)
    );

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Stream index of a status register or -1 if unknown
    function automatic int channel_of(input logic [6:0] addr);
        if (addr == VOLT_ADDR) return 0;
        if (addr == CURR_ADDR) return 1;
        return -1;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // --------------------------------------------------
    // XADC DRP model
    // --------------------------------------------------

    always @(posedge xadc_dclk) begin
        logic [6:0]  want_addr;
        logic [15:0] word;
        model_cycle++;
        xadc_drdy <= 1'b0;
        if (rst_n && xadc_den) begin
            want_addr = expect_current ? CURR_ADDR : VOLT_ADDR;
            assert (!model_busy) else fail_run("DRP enable came while a read was outstanding");
            assert (xadc_daddr == want_addr) else fail_run($sformatf(
                "Mismatch at %0t: xadc_daddr got %h expected %h", $time, xadc_daddr, want_addr));
            if (expect_current) begin
                // Voltage word must already sit in its FIFO
                assert (v_returned - v_popped <= DEPTH && model_cycle - v_drdy_cycle >= 4)
                    else fail_run("Current read started before the voltage word was pushed");
            end
            expect_current = !expect_current;
            pending_addr   = xadc_daddr;
            rng            = next_rand(rng);
            wait_cnt       = 1 + int'(rng[31:16] % 16'd6);  // 1 to 6 cycles
            model_busy     = 1'b1;
            den_count++;
        end else if (model_busy) begin
            wait_cnt--;
            if (wait_cnt == 0) begin
                rng  = next_rand(rng);
                word = rng[31:16];
                xadc_drdy <= 1'b1;
                xadc_do   <= word;
                model_busy = 1'b0;
                case (channel_of(pending_addr))
                    0: begin
                        exp_voltage.push_back(word);
                        v_returned++;
                        v_drdy_cycle = model_cycle;
                    end
                    1: begin
                        exp_current.push_back(word);
                        c_returned++;
                    end
                    default: fail_run("DRP read of an address outside the channel list");
                endcase
            end
        end
    end

    // --------------------------------------------------
    // Stream checker and run limit
    // --------------------------------------------------

    always @(posedge xadc_dclk) begin
        if (rst_n) begin
            if (!eos_seen) begin
                assert (!xadc_den && !voltage_tvalid && !current_tvalid)
                    else fail_run("DUT active before the first end-of-sequence pulse");
                assert (xadc_daddr == VOLT_ADDR) else fail_run($sformatf(
                    "Mismatch at %0t: xadc_daddr got %h expected %h",
                    $time, xadc_daddr, VOLT_ADDR));
            end
            if (xadc_eos) eos_seen = 1'b1;
            if (voltage_tvalid && voltage_tready) begin
                assert (exp_voltage.size() != 0)
                    else fail_run("Voltage stream sent an extra word");
                assert (voltage_tdata == exp_voltage[0]) else fail_run($sformatf(
                    "Mismatch at %0t: voltage_tdata got %h expected %h",
                    $time, voltage_tdata, exp_voltage[0]));
                void'(exp_voltage.pop_front());
                v_popped++;
            end
            if (current_tvalid && current_tready) begin
                assert (exp_current.size() != 0)
                    else fail_run("Current stream sent an extra word");
                assert (current_tdata == exp_current[0]) else fail_run($sformatf(
                    "Mismatch at %0t: current_tdata got %h expected %h",
                    $time, current_tdata, exp_current[0]));
                void'(exp_current.pop_front());
            end
        end
    end

    always @(posedge xadc_dclk) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) fail_run("Timeout, the run went past its cycle limit");
    end

    task automatic pulse_eos();
        @(posedge xadc_dclk);
        xadc_eos <= 1'b1;
        @(posedge xadc_dclk);
        xadc_eos <= 1'b0;
    endtask

    task automatic run_sweep(input int extra_eos_gap);
        int target;
        target = c_returned + 1;
        pulse_eos();
        idle_eos++;
        if (extra_eos_gap > 0) begin
            repeat (extra_eos_gap) @(posedge xadc_dclk);
            pulse_eos();  // Lands mid-sweep
        end
        while (c_returned < target) @(posedge xadc_dclk);
        repeat (2) @(posedge xadc_dclk);  // Push and then sequencer idle
    endtask

    task automatic wait_drained();
        while (exp_voltage.size() != 0 || exp_current.size() != 0) @(posedge xadc_dclk);
    endtask

    initial begin
        int v_target;
        int c_target;
        xadc_eos       = 1'b0;
        voltage_tready = 1'b1;
        current_tready = 1'b1;
        @(posedge rst_n);
        repeat (5) @(posedge xadc_dclk);

        for (int i = 0; i < SWEEPS; i++) begin
            run_sweep((i % 4 == 1) ? 3 : 0);
            repeat (i % 3) @(posedge xadc_dclk);
        end
        wait_drained();

        // Back-pressure where both FIFOs fill and the next voltage word stalls
        @(posedge xadc_dclk);
        voltage_tready <= 1'b0;
        current_tready <= 1'b0;
        for (int i = 0; i < DEPTH; i++) run_sweep(0);
        v_target = v_returned + 1;
        c_target = c_returned + 1;
        pulse_eos();
        idle_eos++;
        while (v_returned < v_target) @(posedge xadc_dclk);
        pulse_eos();
        repeat (20) @(posedge xadc_dclk);
        assert (den_count == 2 * idle_eos - 1)
            else fail_run("DRP read issued while the voltage FIFO was full");
        assert (voltage_tvalid && current_tvalid) else fail_run("A full FIFO lost its words");
        voltage_tready <= 1'b1;
        current_tready <= 1'b1;
        while (c_returned < c_target) @(posedge xadc_dclk);
        wait_drained();

        repeat (5) @(posedge xadc_dclk);
        assert (!expect_current && !model_busy) else fail_run("A sweep was left unfinished");
        assert (den_count == 2 * idle_eos) else fail_run($sformatf(
            "Mismatch at %0t: xadc_den pulses got %0d expected %0d",
            $time, den_count, 2 * idle_eos));
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- xadc_drp_axis.f
+incdir+include
source/xadc_drp_pkg.sv
source/xadc_req_io.sv
source/xadc_channel_sequencer.sv
source/xadc_drp_reader.sv
source/axis_sample_fifo.sv
source/xadc_drp_axis_top.sv
verif/tb_clock_gen.sv
verif/tb_xadc_drp_axis.sv
